// File: source/s16_pkg.sv
// Region codes, bus widths, alternate game id and joystick bit sort
package s16_pkg;

    // CPU word address and data widths
    localparam int addr_w = 23;
    localparam int data_w = 16;

    // Game that uses the alternate cabinet layout
    localparam logic [7:0] game_sdi = 8'd1;

    // One code per chip select region
    typedef enum logic [2:0] {
        region_none = 3'd0,
        region_rom  = 3'd1,
        region_vram = 3'd2,
        region_char = 3'd3,
        region_obj  = 3'd4,
        region_pal  = 3'd5,
        region_io   = 3'd6,
        region_ram  = 3'd7
    } region_t;

    // Joystick byte in the order the cabinet wiring expects
    function automatic logic [7:0] sort_joy(input logic [7:0] joy);
        logic [7:0] sorted;
        sorted = {joy[1:0], joy[3:2], joy[7], joy[5:4], joy[6]};
        return sorted;
    endfunction

endpackage

// File: source/s16_cen_frac.sv
// Fractional clock enable that sets the CPU cycle rate
module s16_cen_frac #(
    parameter int CEN_NUM = 29,
    parameter int CEN_DEN = 146
) (
    input  logic clk,
    input  logic rst,
    output logic cpu_cen
);

    // One spare bit so the sum never wraps before the compare
    localparam int acc_w = $clog2(CEN_DEN + 1) + 1;

    logic [acc_w-1:0] acc;
    logic [acc_w-1:0] acc_sum;

    assign acc_sum = acc + acc_w'(CEN_NUM);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            acc     <= '0;
            cpu_cen <= 1'b0;
        end else if (acc_sum >= acc_w'(CEN_DEN)) begin
            acc     <= acc_sum - acc_w'(CEN_DEN);   // Keep the remainder
            cpu_cen <= 1'b1;
        end else begin
            acc     <= acc_sum;
            cpu_cen <= 1'b0;
        end
    end

    // Ratio must stay below one
    if (CEN_NUM >= CEN_DEN) begin : g_bad_ratio
        $error("s16_cen_frac: CEN_NUM must be below CEN_DEN");
    end

    // A single enable pulse per CPU cycle
    a_cen_single: assert property (
        @(posedge clk) disable iff (rst) cpu_cen |=> !cpu_cen
    ) else $error("cpu_cen high for two cycles");

endmodule

// File: source/s16_addr_dec.sv
// Registered memory map decoder with chip selects and bus error
module s16_addr_dec
    import s16_pkg::*;
(
    input  logic            clk,
    input  logic            rst,
    input  logic [addr_w:1] addr,
    input  logic            as_n,
    input  logic            uds_n,
    input  logic            lds_n,
    output region_t         region,
    output logic            berr_n,
    output logic            rom_cs,
    output logic            vram_cs,
    output logic            ram_cs,
    output logic            char_cs,
    output logic            pal_cs,
    output logic            obj_cs
);

    logic [1:0] hi;
    logic [2:0] mid;
    logic       strobe;
    region_t    next_region;

    assign hi     = addr[23:22];
    assign mid    = addr[18:16];
    assign strobe = !uds_n || !lds_n;   // RAM needs a byte lane

    // First matching rule wins
    always_comb begin
        if (hi == 2'd0 && !addr[18]) begin
            next_region = region_rom;
        end else if (addr[22] && mid == 3'd0 && strobe) begin
            next_region = region_vram;
        end else if (addr[22] && mid == 3'd1) begin
            next_region = region_char;
        end else if (hi == 2'd1 && addr[18]) begin
            next_region = region_obj;
        end else if (hi == 2'd2 && addr[18]) begin
            next_region = region_pal;
        end else if (hi == 2'd3 && addr[18:17] == 2'd2) begin
            next_region = region_io;
        end else if (hi == 2'd3 && mid == 3'd7 && strobe) begin
            next_region = region_ram;
        end else begin
            next_region = region_none;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            region <= region_none;
            berr_n <= 1'b1;
        end else begin
            region <= as_n ? region_none : next_region;
            berr_n <= as_n || next_region != region_none;
        end
    end

    assign rom_cs  = region == region_rom;
    assign vram_cs = region == region_vram;
    assign ram_cs  = region == region_ram;
    assign char_cs = region == region_char;
    assign pal_cs  = region == region_pal;
    assign obj_cs  = region == region_obj;

    a_cs_release: assert property (
        @(posedge clk) disable iff (rst) $rose(as_n) |=> region == region_none
    ) else $error("Chip select still active after the address strobe ended");

endmodule

// File: source/s16_bus_fsm.sv
// Bus cycle FSM that returns DTACK once memory is ready
module s16_bus_fsm
    import s16_pkg::*;
(
    input  logic    clk,
    input  logic    rst,
    input  logic    cpu_cen,
    input  logic    as_n,
    input  region_t region,
    input  logic    rom_ok,
    input  logic    ram_ok,
    output logic    dtack_n
);

    typedef enum logic [1:0] {
        st_idle,
        st_wait,
        st_ack
    } state_t;

    state_t state;
    logic   ready;

    // Only ROM and the SDRAM backed regions can stall
    always_comb begin
        case (region)
            region_rom:              ready = rom_ok;
            region_vram, region_ram: ready = ram_ok;
            default:                 ready = 1'b1;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state   <= st_idle;
            dtack_n <= 1'b1;
        end else begin
            case (state)
                st_idle, st_wait: begin
                    if (as_n || region == region_none) begin
                        state <= st_idle;
                    end else if (cpu_cen && ready) begin
                        state   <= st_ack;
                        dtack_n <= 1'b0;
                    end else begin
                        state <= st_wait;   // Back pressure
                    end
                end
                default: begin
                    if (as_n) begin
                        state   <= st_idle;
                        dtack_n <= 1'b1;
                    end
                end
            endcase
        end
    end

    a_dtack_mapped: assert property (
        @(posedge clk) disable iff (rst) !dtack_n |-> region != region_none
    ) else $error("DTACK asserted without a selected region");

endmodule

// File: source/s16_cab_io.sv
// Cabinet input register for joysticks, buttons and DIP switches
module s16_cab_io
    import s16_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  region_t     region,
    input  logic [13:1] addr,
    input  logic [7:0]  game_id,
    input  logic [7:0]  joystick1,
    input  logic [7:0]  joystick2,
    input  logic [1:0]  start_button,
    input  logic [1:0]  coin_input,
    input  logic        service,
    input  logic        dip_test,
    input  logic        ana_sel,
    input  logic [15:0] joyana1,
    input  logic [15:0] joyana2,
    input  logic [7:0]  dipsw_a,
    input  logic [7:0]  dipsw_b,
    output logic [7:0]  cab_dout
);

    logic       is_sdi;
    logic [7:0] sort1;
    logic [7:0] sort2;
    logic [7:0] ana1;
    logic [7:0] ana2;
    logic [7:0] cab_next;

    assign is_sdi = game_id == game_sdi;
    assign sort1  = sort_joy(joystick1);
    assign sort2  = sort_joy(joystick2);
    // Analog select flips to the inverted high byte
    assign ana1   = ana_sel ? ~joyana1[15:8] : joyana1[7:0];
    assign ana2   = ana_sel ? ~joyana2[15:8] : joyana2[7:0];

    always_comb begin
        cab_next = 8'hff;
        if (addr[13:12] == 2'd1) begin
            case (addr[2:1])
                2'd0: begin
                    cab_next = {2'b11, start_button, service, dip_test, coin_input};
                    if (is_sdi) begin
                        cab_next[7:6] = {joystick2[4], joystick1[4]};   // Fire buttons
                    end
                end
                2'd1:    cab_next = is_sdi ? ana1 : sort1;
                2'd2:    cab_next = is_sdi ? {sort2[7:4], sort1[7:4]} : 8'hff;
                default: cab_next = is_sdi ? ana2 : sort2;
            endcase
        end else if (addr[13:12] == 2'd2) begin
            cab_next = addr[1] ? dipsw_b : dipsw_a;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cab_dout <= 8'hff;
        end else begin
            cab_dout <= region == region_io ? cab_next : 8'hff;
        end
    end

endmodule

// File: source/s16_rdata_mux.sv
// Registered read data selector for the CPU input bus
module s16_rdata_mux
    import s16_pkg::*;
(
    input  logic              clk,
    input  logic              rst,
    input  region_t           region,
    input  logic [data_w-1:0] rom_data,
    input  logic [data_w-1:0] ram_data,
    input  logic [data_w-1:0] char_data,
    input  logic [data_w-1:0] pal_data,
    input  logic [data_w-1:0] obj_data,
    input  logic [7:0]        cab_dout,
    output logic [data_w-1:0] cpu_din
);

    logic [data_w-1:0] din_next;

    always_comb begin
        case (region)
            region_rom:              din_next = rom_data;   // No decryption
            region_vram, region_ram: din_next = ram_data;   // Shared memory port
            region_char:             din_next = char_data;
            region_pal:              din_next = pal_data;
            region_obj:              din_next = obj_data;
            region_io:               din_next = {8'hff, cab_dout};
            default:                 din_next = '1;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cpu_din <= '1;
        end else begin
            cpu_din <= din_next;
        end
    end

endmodule

// File: source/s16_vblank_irq.sv
// Vertical blank interrupt request with acknowledge clear
module s16_vblank_irq #(
    parameter int VBL_LINE = 223
) (
    input  logic       clk,
    input  logic       rst,
    input  logic [8:0] vdump,
    input  logic       hstart,
    input  logic [2:0] fc,
    input  logic       as_n,
    output logic       irq_n
);

    logic last_hstart;
    logic hstart_rise;
    logic int_ack;

    assign hstart_rise = hstart && !last_hstart;
    // Interrupt acknowledge cycle has all function code bits set
    assign int_ack     = fc == 3'd7 && !as_n;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            last_hstart <= 1'b0;
            irq_n       <= 1'b1;
        end else begin
            last_hstart <= hstart;
            if (int_ack) begin
                irq_n <= 1'b1;   // Ack beats a new request
            end else if (hstart_rise && vdump == 9'(VBL_LINE)) begin
                irq_n <= 1'b0;
            end
        end
    end

endmodule

// File: source/s16_main_bus.sv
// Main bus top level with decoder, clock enable, DTACK FSM and read path
module s16_main_bus
    import s16_pkg::*;
#(
    parameter int CEN_NUM  = 29,
    parameter int CEN_DEN  = 146,
    parameter int VBL_LINE = 223
) (
    input  logic              clk,
    input  logic              rst,
    // 68000 bus master
    input  logic [addr_w:1]   addr,
    input  logic              as_n,
    input  logic              uds_n,
    input  logic              lds_n,
    input  logic              rnw,
    input  logic [2:0]        fc,
    // Memories
    input  logic              rom_ok,
    input  logic              ram_ok,
    input  logic [data_w-1:0] rom_data,
    input  logic [data_w-1:0] ram_data,
    input  logic [data_w-1:0] char_data,
    input  logic [data_w-1:0] pal_data,
    input  logic [data_w-1:0] obj_data,
    // Cabinet
    input  logic [7:0]        game_id,
    input  logic [7:0]        joystick1,
    input  logic [7:0]        joystick2,
    input  logic [1:0]        start_button,
    input  logic [1:0]        coin_input,
    input  logic              service,
    input  logic              dip_test,
    input  logic              ana_sel,
    input  logic [15:0]       joyana1,
    input  logic [15:0]       joyana2,
    input  logic [7:0]        dipsw_a,
    input  logic [7:0]        dipsw_b,
    input  logic              ppi_flip,   // Screen flip from the PPI port
    // Video timing
    input  logic [8:0]        vdump,
    input  logic              hstart,
    output logic              cpu_cen,
    output logic              dtack_n,
    output logic              berr_n,
    output logic              irq_n,
    output logic [data_w-1:0] cpu_din,
    output logic              rom_cs,
    output logic              vram_cs,
    output logic              ram_cs,
    output logic              char_cs,
    output logic              pal_cs,
    output logic              obj_cs,
    output logic              uds_wn,   // Upper byte write strobe
    output logic              lds_wn,   // Lower byte write strobe
    output logic              flip
);

    region_t    region;
    logic [7:0] cab_dout;

    assign flip   = ppi_flip;
    assign uds_wn = rnw | uds_n;
    assign lds_wn = rnw | lds_n;

    s16_cen_frac #(
        .CEN_NUM (CEN_NUM),
        .CEN_DEN (CEN_DEN)
    ) u_cen (
        .clk     (clk),
        .rst     (rst),
        .cpu_cen (cpu_cen)
    );

    s16_addr_dec u_dec (
        .clk     (clk),
        .rst     (rst),
        .addr    (addr),
        .as_n    (as_n),
        .uds_n   (uds_n),
        .lds_n   (lds_n),
        .region  (region),
        .berr_n  (berr_n),
        .rom_cs  (rom_cs),
        .vram_cs (vram_cs),
        .ram_cs  (ram_cs),
        .char_cs (char_cs),
        .pal_cs  (pal_cs),
        .obj_cs  (obj_cs)
    );

    s16_bus_fsm u_fsm (
        .clk     (clk),
        .rst     (rst),
        .cpu_cen (cpu_cen),
        .as_n    (as_n),
        .region  (region),
        .rom_ok  (rom_ok),
        .ram_ok  (ram_ok),
        .dtack_n (dtack_n)
    );

    s16_cab_io u_cab (
        .clk          (clk),
        .rst          (rst),
        .region       (region),
        .addr         (addr[13:1]),
        .game_id      (game_id),
        .joystick1    (joystick1),
        .joystick2    (joystick2),
        .start_button (start_button),
        .coin_input   (coin_input),
        .service      (service),
        .dip_test     (dip_test),
        .ana_sel      (ana_sel),
        .joyana1      (joyana1),
        .joyana2      (joyana2),
        .dipsw_a      (dipsw_a),
        .dipsw_b      (dipsw_b),
        .cab_dout     (cab_dout)
    );

    s16_rdata_mux u_mux (
        .clk       (clk),
        .rst       (rst),
        .region    (region),
        .rom_data  (rom_data),
        .ram_data  (ram_data),
        .char_data (char_data),
        .pal_data  (pal_data),
        .obj_data  (obj_data),
        .cab_dout  (cab_dout),
        .cpu_din   (cpu_din)
    );

    s16_vblank_irq #(
        .VBL_LINE (VBL_LINE)
    ) u_irq (
        .clk    (clk),
        .rst    (rst),
        .vdump  (vdump),
        .hstart (hstart),
        .fc     (fc),
        .as_n   (as_n),
        .irq_n  (irq_n)
    );

endmodule

// File: tb/s16_tb_clk.sv
// Testbench clock and reset source
module s16_tb_clk (
    output logic clk,
    output logic rst
);
    timeunit 1ns;
    timeprecision 100ps;

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;   // 100 ns period
    end

    initial begin
        rst = 1'b1;
        repeat (3) @(posedge clk);
        rst <= 1'b0;
    end

endmodule

// File: tb/s16_main_bus_tb.sv
// Main bus testbench with 68000 bus master, reference model and concurrent checks
module s16_main_bus_tb
    import s16_pkg::*;
;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int cen_num  = 29;
    localparam int cen_den  = 146;
    localparam int vbl_line = 223;
    localparam int seed     = 58655;
    // 200 bus cycles of at most 15 clocks, plus reset and interrupt tests
    localparam int cycle_limit = 200 * 15 + 1000;

    logic clk;
    logic rst;
    logic [addr_w:1] addr;
    logic as_n, uds_n, lds_n, rnw;
    logic [2:0] fc;
    logic rom_ok, ram_ok;
    logic [data_w-1:0] rom_data, ram_data, char_data, pal_data, obj_data;
    logic [7:0] game_id, joystick1, joystick2, dipsw_a, dipsw_b;
    logic [1:0] start_button, coin_input;
    logic service, dip_test, ana_sel, ppi_flip, hstart;
    logic [15:0] joyana1, joyana2;
    logic [8:0] vdump;
    logic cpu_cen, dtack_n, berr_n, irq_n;
    logic [data_w-1:0] cpu_din;
    logic rom_cs, vram_cs, ram_cs, char_cs, pal_cs, obj_cs;
    logic uds_wn, lds_wn, flip;

    // Reference model state
    region_t exp_region;
    logic exp_berr_n;
    logic [7:0] exp_cab;
    logic [data_w-1:0] exp_din;
    logic [cen_den-1:0] cen_hist;
    logic [5:0] cs_vec;
    logic lane, mem_ready, int_ack;
    int cen_seen;
    int errors;
    int bus_count;
    int cycles;

    s16_tb_clk u_clk (
        .clk (clk),
        .rst (rst)
    );

    s16_main_bus #(
        .CEN_NUM  (cen_num),
        .CEN_DEN  (cen_den),
        .VBL_LINE (vbl_line)
    ) u_dut (.*);

    assign cs_vec  = {rom_cs, vram_cs, ram_cs, char_cs, pal_cs, obj_cs};
    assign lane    = !uds_n || !lds_n;
    assign int_ack = fc == 3'd7 && !as_n;
    assign mem_ready = exp_region == region_rom ? rom_ok :
                       (exp_region == region_vram || exp_region == region_ram) ? ram_ok : 1'b1;

    // First matching memory map rule wins
    function automatic region_t map_region(input logic [23:1] a, input logic strobe);
        if (a[23:22] == 2'd0 && !a[18])
            return region_rom;
        if (a[22] && a[18:16] == 3'd0 && strobe)
            return region_vram;
        if (a[22] && a[18:16] == 3'd1)
            return region_char;
        if (a[23:22] == 2'd1 && a[18])
            return region_obj;
        if (a[23:22] == 2'd2 && a[18])
            return region_pal;
        if (a[23:22] == 2'd3 && a[18:17] == 2'd2)
            return region_io;
        if (a[23:22] == 2'd3 && a[18:16] == 3'd7 && strobe)
            return region_ram;
        return region_none;
    endfunction

    // Chip select order is rom, vram, ram, char, pal, obj
    function automatic logic [5:0] cs_of(input region_t r);
        case (r)
            region_rom:  return 6'b100000;
            region_vram: return 6'b010000;
            region_ram:  return 6'b001000;
            region_char: return 6'b000100;
            region_pal:  return 6'b000010;
            region_obj:  return 6'b000001;
            default:     return 6'b000000;
        endcase
    endfunction

    // Cabinet wiring of one joystick byte
    function automatic logic [7:0] wire_joy(input logic [7:0] j);
        return {j[1], j[0], j[3], j[2], j[7], j[5], j[4], j[6]};
    endfunction

    function automatic logic [7:0] cab_byte(input logic [13:1] a);
        logic sdi;
        logic [7:0] p0;
        logic [7:0] j1s;
        logic [7:0] j2s;
        logic [7:0] an1;
        logic [7:0] an2;
        sdi = game_id == game_sdi;
        j1s = wire_joy(joystick1);
        j2s = wire_joy(joystick2);
        an1 = ana_sel ? ~joyana1[15:8] : joyana1[7:0];
        an2 = ana_sel ? ~joyana2[15:8] : joyana2[7:0];
        p0  = {2'b11, start_button, service, dip_test, coin_input};
        if (sdi)
            p0[7:6] = {joystick2[4], joystick1[4]};
        if (a[13:12] == 2'd2)
            return a[1] ? dipsw_b : dipsw_a;
        if (a[13:12] != 2'd1)
            return 8'hff;
        case (a[2:1])
            2'd0:    return p0;
            2'd1:    return sdi ? an1 : j1s;
            2'd2:    return sdi ? {j2s[7:4], j1s[7:4]} : 8'hff;
            default: return sdi ? an2 : j2s;
        endcase
    endfunction

    function automatic logic [data_w-1:0] din_of(input region_t r, input logic [7:0] cab);
        case (r)
            region_rom:              return rom_data;
            region_vram, region_ram: return ram_data;
            region_char:             return char_data;
            region_pal:              return pal_data;
            region_obj:              return obj_data;
            region_io:               return {8'hff, cab};
            default:                 return 16'hffff;
        endcase
    endfunction

    // Random address forced into one region
    function automatic logic [23:1] region_addr(input region_t r);
        logic [23:1] a;
        a = 23'($urandom());
        case (r)
            region_rom: begin
                a[23:22] = 2'd0;
                a[18]    = 1'b0;
            end
            region_vram: begin
                a[22]    = 1'b1;
                a[18:16] = 3'd0;
            end
            region_char: begin
                a[22]    = 1'b1;
                a[18:16] = 3'd1;
            end
            region_obj: begin
                a[23:22] = 2'd1;
                a[18]    = 1'b1;
            end
            region_pal: begin
                a[23:22] = 2'd2;
                a[18]    = 1'b1;
            end
            region_io: begin
                a[23:22] = 2'd3;
                a[18:17] = 2'd2;
            end
            default: begin
                a[23:22] = 2'd3;
                a[18:16] = 3'd7;
            end
        endcase
        return a;
    endfunction

    // Pipeline of decoder, cabinet register and read mux
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            exp_region <= region_none;
            exp_berr_n <= 1'b1;
            exp_cab    <= 8'hff;
            exp_din    <= 16'hffff;
        end else begin
            exp_region <= as_n ? region_none : map_region(addr, lane);
            exp_berr_n <= as_n || map_region(addr, lane) != region_none;
            exp_cab    <= exp_region == region_io ? cab_byte(addr[13:1]) : 8'hff;
            exp_din    <= din_of(exp_region, exp_cab);
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cen_hist <= '0;
            cen_seen <= 0;
        end else begin
            cen_hist <= {cen_hist[cen_den-2:0], cpu_cen};   // Last cen_den samples
            if (cen_seen <= cen_den)
                cen_seen <= cen_seen + 1;
        end
    end

    task automatic flag_error(input string msg);
        errors++;
        $display("ERROR %0t: %s", $time, msg);
    endtask

    a_reset_state: assert property (@(posedge clk) $fell(rst) |->
        dtack_n && berr_n && irq_n && cpu_din == 16'hffff && cs_vec == 6'd0)
        else flag_error("outputs not idle after reset");
    a_chip_sel: assert property (@(posedge clk) disable iff (rst) cs_vec == cs_of(exp_region))
        else flag_error("chip selects do not match the memory map");
    a_berr: assert property (@(posedge clk) disable iff (rst) berr_n == exp_berr_n)
        else flag_error("bus error does not match the memory map");
    a_berr_no_dtack: assert property (@(posedge clk) disable iff (rst) !berr_n |-> dtack_n)
        else flag_error("DTACK together with bus error");
    a_cen_rate: assert property (@(posedge clk) disable iff (rst)
        cen_seen > cen_den |-> $countones(cen_hist) == cen_num)
        else flag_error("wrong cpu_cen count in window");
    a_dtack_ready: assert property (@(posedge clk) disable iff (rst) $fell(dtack_n) |->
        $past(cpu_cen && mem_ready && !as_n && exp_region != region_none))
        else flag_error("DTACK without cpu_cen or ready memory");
    a_dtack_prompt: assert property (@(posedge clk) disable iff (rst)
        dtack_n && !as_n && exp_region != region_none && cpu_cen && mem_ready |=> !dtack_n)
        else flag_error("DTACK late");
    a_dtack_hold: assert property (@(posedge clk) disable iff (rst)
        !dtack_n && !as_n |=> !dtack_n)
        else flag_error("DTACK dropped during the strobe");
    a_dtack_release: assert property (@(posedge clk) disable iff (rst) $rose(as_n) |=> dtack_n)
        else flag_error("DTACK not released after the strobe");
    a_read_data: assert property (@(posedge clk) disable iff (rst) !dtack_n |-> cpu_din == exp_din)
        else flag_error("read data mismatch");
    a_flip: assert property (@(posedge clk) disable iff (rst) flip == ppi_flip)
        else flag_error("flip does not follow the PPI bit");
    a_write_strobe: assert property (@(posedge clk) disable iff (rst)
        {uds_wn, lds_wn} == (rnw ? 2'b11 : {uds_n, lds_n}))
        else flag_error("byte write strobes do not follow the bus master");
    a_irq_set: assert property (@(posedge clk) disable iff (rst)
        $rose(hstart) && vdump == 9'(vbl_line) && !int_ack |=> !irq_n)
        else flag_error("no interrupt at the blanking line");
    a_irq_other: assert property (@(posedge clk) disable iff (rst)
        $rose(hstart) && vdump != 9'(vbl_line) && irq_n |=> irq_n)
        else flag_error("interrupt at a wrong line");
    a_irq_hold: assert property (@(posedge clk) disable iff (rst) !irq_n && !int_ack |=> !irq_n)
        else flag_error("interrupt dropped without acknowledge");
    a_irq_ack: assert property (@(posedge clk) disable iff (rst) int_ack |=> irq_n)
        else flag_error("interrupt not cleared by acknowledge");

    // One 68000 bus cycle with fresh data and separate ROM and RAM stalls
    task automatic bus_cycle(input logic [23:1] a, input logic [1:0] strb, input logic rd,
                             input logic [2:0] f, input logic [7:0] gid, input logic asel);
        int rom_wait;
        int ram_wait;
        rom_wait = $urandom_range(5, 0);
        ram_wait = $urandom_range(5, 0);
        @(posedge clk);
        addr         <= a;
        uds_n        <= strb[1];
        lds_n        <= strb[0];
        fc           <= f;
        rnw          <= rd;
        game_id      <= gid;
        ana_sel      <= asel;
        rom_data     <= 16'($urandom());
        ram_data     <= 16'($urandom());
        char_data    <= 16'($urandom());
        pal_data     <= 16'($urandom());
        obj_data     <= 16'($urandom());
        joystick1    <= 8'($urandom());
        joystick2    <= 8'($urandom());
        start_button <= 2'($urandom());
        coin_input   <= 2'($urandom());
        service      <= 1'($urandom());
        dip_test     <= 1'($urandom());
        joyana1      <= 16'($urandom());
        joyana2      <= 16'($urandom());
        dipsw_a      <= 8'($urandom());
        dipsw_b      <= 8'($urandom());
        ppi_flip     <= 1'($urandom());
        as_n         <= 1'b0;
        rom_ok       <= rom_wait == 0;
        ram_ok       <= ram_wait == 0;
        do begin
            @(posedge clk);
            if (rom_wait > 0)
                rom_wait--;
            if (ram_wait > 0)
                ram_wait--;
            rom_ok <= rom_wait == 0;
            ram_ok <= ram_wait == 0;
        end while (dtack_n && berr_n);
        as_n <= 1'b1;   // Strobe ends on the edge that saw the answer
        bus_count++;
    endtask

    task automatic pulse_hstart(input logic [8:0] line);
        @(posedge clk);
        vdump  <= line;
        hstart <= 1'b1;
        @(posedge clk);
        hstart <= 1'b0;
        repeat (3) @(posedge clk);
    endtask

    initial begin
        int i;
        region_t r;
        void'($urandom(seed));
        errors = 0;
        bus_count = 0;
        addr = '0;
        as_n = 1'b1;
        uds_n = 1'b1;
        lds_n = 1'b1;
        rnw = 1'b1;
        fc = 3'd0;
        rom_ok = 1'b1;
        ram_ok = 1'b1;
        {rom_data, ram_data, char_data, pal_data, obj_data} = '0;
        {game_id, joystick1, joystick2, dipsw_a, dipsw_b} = '0;
        {start_button, coin_input, service, dip_test, ana_sel, ppi_flip} = '0;
        {joyana1, joyana2} = '0;
        vdump = 9'd0;
        hstart = 1'b0;
        @(negedge rst);
        // Random addresses and directions where both strobes may be high
        for (i = 0; i < 100; i++) begin
            bus_cycle(23'($urandom()), 2'($urandom_range(3, 0)), 1'($urandom()), 3'd5,
                      8'd0, 1'b0);
        end
        // Reads from each memory region
        for (i = 0; i < 36; i++) begin
            r = (i % 6 == 5) ? region_ram : region_t'(3'(i % 6 + 1));
            bus_cycle(region_addr(r), 2'($urandom_range(2, 0)), 1'b1, 3'd5, 8'd0, 1'b0);
        end
        // Cabinet reads in both layouts
        for (i = 0; i < 64; i++) begin
            bus_cycle(region_addr(region_io), 2'($urandom_range(2, 0)), 1'b1, 3'd5,
                      i[1] ? game_sdi : 8'd0, i[0]);
        end
        pulse_hstart(9'd100);
        pulse_hstart(9'(vbl_line));
        bus_cycle('1, 2'b10, 1'b1, 3'd7, 8'd0, 1'b0);   // Interrupt acknowledge
        repeat (4) @(posedge clk);
        $display("Bus cycles: %0d, errors: %0d", bus_count, errors);
        if (errors == 0)
            $display("All tests passed");
        else
            $display("Some tests failed");
        $finish;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles == cycle_limit) begin
            $display("Bus timed out after %0d cycles before the tests finished", cycles);
            $display("Some tests failed");
            $finish;
        end
    end

    initial cycles = 0;

endmodule

// File: s16_main_bus.f
source/s16_pkg.sv
source/s16_cen_frac.sv
source/s16_addr_dec.sv
source/s16_bus_fsm.sv
source/s16_cab_io.sv
source/s16_rdata_mux.sv
source/s16_vblank_irq.sv
source/s16_main_bus.sv
tb/s16_tb_clk.sv
tb/s16_main_bus_tb.sv

// File: run.sh
#!/bin/sh
# Build the main bus testbench with Verilator and run it
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert --timescale 1ns/100ps \
    --top-module s16_main_bus_tb -f s16_main_bus.f -o s16_sim
out=$(./obj_dir/s16_sim)
echo "$out"
if echo "$out" | grep -q "All tests passed"; then
    exit 0
fi
exit 1
